// ==== design/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Register and memory word width
`define dataWidth 32

// 32 general purpose registers
`define regAddrWidth 5

// Data memory holds 64 words
`define dataMemDepthLog2 6

`define instrAddrWidth 32

`endif

// ==== design/mipsInstrPkg.sv ====
package mipsInstrPkg;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instrRT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] immediate;
	} instrIT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target;
	} instrJT;

	// One fetched word, read in whichever format the opcode calls for
	typedef union packed {
		instrRT r;
		instrIT i;
		instrJT j;
	} instrWordU;

	typedef enum logic {sourceOp, sourceFunc} opFuncSourceE;

	// Code is the opcode, or the funct when the opcode is zero
	typedef struct packed {
		opFuncSourceE source;
		logic [5:0] code;
	} opFuncT;

	typedef struct packed {
		logic arith;
		logic logical;
		logic rShift;
		logic load;
		logic store;
		logic branch;
		logic jump;
		logic rJump;
		logic lui;
	} categoryT;

	localparam opFuncT opAddiu = '{source: sourceOp, code: 6'h09};
	localparam opFuncT opAndi = '{source: sourceOp, code: 6'h0c};
	localparam opFuncT opOri = '{source: sourceOp, code: 6'h0d};
	localparam opFuncT opLui = '{source: sourceOp, code: 6'h0f};
	localparam opFuncT opLw = '{source: sourceOp, code: 6'h23};
	localparam opFuncT opSw = '{source: sourceOp, code: 6'h2b};
	localparam opFuncT opBeq = '{source: sourceOp, code: 6'h04};
	localparam opFuncT opBne = '{source: sourceOp, code: 6'h05};
	localparam opFuncT opJ = '{source: sourceOp, code: 6'h02};
	localparam opFuncT funcSll = '{source: sourceFunc, code: 6'h00};
	localparam opFuncT funcSrl = '{source: sourceFunc, code: 6'h02};
	localparam opFuncT funcJr = '{source: sourceFunc, code: 6'h08};
	localparam opFuncT funcAddu = '{source: sourceFunc, code: 6'h21};
	localparam opFuncT funcSubu = '{source: sourceFunc, code: 6'h23};
	localparam opFuncT funcAnd = '{source: sourceFunc, code: 6'h24};
	localparam opFuncT funcOr = '{source: sourceFunc, code: 6'h25};
	localparam opFuncT funcSlt = '{source: sourceFunc, code: 6'h2a};

endpackage

// ==== design/mipsControlPkg.sv ====
`include "mips_config.svh"

package mipsControlPkg;

	typedef enum logic {writeAddrRd, writeAddrRt} regWriteAddrSourceE;
	typedef enum logic {writeDataAlu, writeDataMemory} regWriteDataSourceE;
	typedef enum logic {reg1Rs, reg1Rt} reg1AddrSourceE;
	typedef enum logic [1:0] {
		aluData2Register,
		aluData2ImmSigned,
		aluData2ImmUnsigned
	} aluData2SourceE;
	typedef enum logic [1:0] {shamtFromShamt, shamtConst16, shamtNone} shamtSourceE;

	typedef enum logic [1:0] {pcInc, pcBranch, pcJump} pcActionE;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluSll,
		aluSrl
	} aluOpE;

	typedef enum logic {branchEq, branchNe} branchCondE;

	typedef struct packed {
		regWriteAddrSourceE regWriteAddrSource;
		regWriteDataSourceE regWriteDataSource;
		reg1AddrSourceE reg1AddrSource;
		aluData2SourceE aluData2Source;
		shamtSourceE shamtSource;
		pcActionE pcAction;
		aluOpE aluOp;
		branchCondE branchCond;
		logic memWriteEnable;
		logic regWriteEnable;
	} controlT;

	typedef struct packed {
		logic enable;
		logic [`regAddrWidth-1:0] addr;
		logic [`dataWidth-1:0] data;
	} regWriteT;

	// Addr is a word index into data memory
	typedef struct packed {
		logic enable;
		logic [`dataMemDepthLog2-1:0] addr;
		logic [`dataWidth-1:0] data;
	} memWriteT;

endpackage

// ==== design/instructionCategorize.sv ====
`timescale 1ns/1ns

module instructionCategorize (
	input mipsInstrPkg::opFuncT opFunc,
	output mipsInstrPkg::categoryT category
);
	import mipsInstrPkg::*;

	always_comb begin
		category = '0;
		case (opFunc)
			funcAddu, funcSubu, funcSlt, opAddiu:
				category.arith = 1'b1;
			funcAnd, funcOr, opAndi, opOri:
				category.logical = 1'b1;
			funcSll, funcSrl:
				category.rShift = 1'b1;
			opLw:
				category.load = 1'b1;
			opSw:
				category.store = 1'b1;
			opBeq, opBne:
				category.branch = 1'b1;
			opJ:
				category.jump = 1'b1;
			funcJr:
				category.rJump = 1'b1;
			opLui:
				category.lui = 1'b1;
			// Unsupported codes fall back to plain arithmetic
			default:
				category.arith = 1'b1;
		endcase
	end

endmodule

// ==== design/controlGenerate.sv ====
`timescale 1ns/1ns

module controlGenerate (
	input mipsInstrPkg::opFuncT opFunc,
	input mipsInstrPkg::categoryT category,
	output mipsControlPkg::controlT control
);
	import mipsInstrPkg::*;
	import mipsControlPkg::*;

	logic isFunc;

	assign isFunc = (opFunc.source == sourceFunc);

	always_comb begin
		control.memWriteEnable = category.store;

		// Stores, branches and jumps leave the register file alone
		control.regWriteEnable = !(category.branch || category.jump || category.rJump ||
			category.store);

		control.regWriteAddrSource = isFunc ? writeAddrRd : writeAddrRt;
		control.regWriteDataSource = category.load ? writeDataMemory : writeDataAlu;
		control.reg1AddrSource = category.rShift ? reg1Rt : reg1Rs;

		if (isFunc || category.branch)
			control.aluData2Source = aluData2Register;
		else if (category.logical)
			control.aluData2Source = aluData2ImmUnsigned;
		else
			control.aluData2Source = aluData2ImmSigned;

		// lui is the immediate shifted left by 16
		if (category.rShift)
			control.shamtSource = shamtFromShamt;
		else if (category.lui)
			control.shamtSource = shamtConst16;
		else
			control.shamtSource = shamtNone;

		if (category.jump || category.rJump)
			control.pcAction = pcJump;
		else if (category.branch)
			control.pcAction = pcBranch;
		else
			control.pcAction = pcInc;

		case (opFunc)
			funcSubu, opBeq, opBne:
				control.aluOp = aluSub;
			funcAnd, opAndi:
				control.aluOp = aluAnd;
			funcOr, opOri:
				control.aluOp = aluOr;
			funcSlt:
				control.aluOp = aluSlt;
			funcSll, opLui:
				control.aluOp = aluSll;
			funcSrl:
				control.aluOp = aluSrl;
			default:
				control.aluOp = aluAdd;
		endcase

		control.branchCond = (opFunc == opBne) ? branchNe : branchEq;
	end

endmodule

// ==== design/sequencer.sv ====
`timescale 1ns/1ns

module sequencer (
	input logic clk,
	input logic reset,
	output logic loadInstr,
	output logic loadOperands,
	output logic loadResult,
	output logic commit
);

	typedef enum logic [1:0] {
		stateFetch,
		stateDecode,
		stateExecute,
		stateWriteback
	} stateE;

	stateE state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stateFetch;
		end else begin
			case (state)
				stateFetch:
					state <= stateDecode;
				stateDecode:
					state <= stateExecute;
				stateExecute:
					state <= stateWriteback;
				default:
					state <= stateFetch;
			endcase
		end
	end

	assign loadInstr = (state == stateFetch);
	assign loadOperands = (state == stateDecode);
	assign loadResult = (state == stateExecute);
	assign commit = (state == stateWriteback);

endmodule

// ==== design/pcCounter.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module pcCounter (
	input logic clk,
	input logic reset,
	input logic commit,
	input mipsControlPkg::pcActionE action,
	input logic branchTaken,
	input logic [15:0] offset,
	input logic [25:0] target,
	input logic jumpRegister,
	input logic [31:0] registerValue,
	output logic [`instrAddrWidth-1:0] pc
);
	import mipsControlPkg::*;

	logic [`instrAddrWidth-1:0] pcPlus4;

	assign pcPlus4 = pc + 4;

	// No delay slot, so targets are taken straight away
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (commit) begin
			case (action)
				pcBranch:
					pc <= branchTaken ? pcPlus4 + {{14{offset[15]}}, offset, 2'b00} : pcPlus4;
				pcJump:
					pc <= jumpRegister ? registerValue : {pcPlus4[31:28], target, 2'b00};
				default:
					pc <= pcPlus4;
			endcase
		end
	end

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module registerFile (
	input logic clk,
	input logic [`regAddrWidth-1:0] readAddr1,
	input logic [`regAddrWidth-1:0] readAddr2,
	output logic [`dataWidth-1:0] readData1,
	output logic [`dataWidth-1:0] readData2,
	input mipsControlPkg::regWriteT write
);

	logic [`dataWidth-1:0] regs [1 << `regAddrWidth];

	always_ff @(posedge clk) begin
		if (write.enable && write.addr != '0) begin
			regs[write.addr] <= write.data;
		end
	end

	// r0 is never stored and always reads as zero
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module alu (
	input mipsControlPkg::aluOpE op,
	input logic [`dataWidth-1:0] a,
	input logic [`dataWidth-1:0] b,
	input logic [4:0] shamt,
	output logic [`dataWidth-1:0] result,
	output logic zero
);
	import mipsControlPkg::*;

	always_comb begin
		case (op)
			aluSub:
				result = a - b;
			aluAnd:
				result = a & b;
			aluOr:
				result = a | b;
			aluSlt:
				result = {{(`dataWidth - 1){1'b0}}, $signed(a) < $signed(b)};
			// Shifts act on b, which also covers lui
			aluSll:
				result = b << shamt;
			aluSrl:
				result = b >> shamt;
			default:
				result = a + b;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== design/dataMemory.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module dataMemory (
	input logic clk,
	input logic [`dataMemDepthLog2-1:0] readAddr,
	output logic [`dataWidth-1:0] readData,
	input mipsControlPkg::memWriteT write
);

	logic [`dataWidth-1:0] mem [1 << `dataMemDepthLog2] = '{default: '0};

	always_ff @(posedge clk) begin
		if (write.enable) begin
			mem[write.addr] <= write.data;
		end
	end

	assign readData = mem[readAddr];

endmodule

// ==== design/mipsCore.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module mipsCore (
	input logic clk,
	input logic reset,
	input mipsInstrPkg::instrWordU instr,
	output logic [`instrAddrWidth-1:0] pc,
	output logic fetch,
	output mipsControlPkg::regWriteT regWrite,
	output mipsControlPkg::memWriteT memWrite
);
	import mipsInstrPkg::*;
	import mipsControlPkg::*;

	logic loadInstr, loadOperands, loadResult, commit;
	instrWordU instrReg;
	opFuncT opFunc;
	categoryT category;
	controlT control;
	logic [`regAddrWidth-1:0] readAddr1;
	logic [`dataWidth-1:0] readData1, readData2;
	logic [`dataWidth-1:0] operandA, operandB;
	logic [`dataWidth-1:0] aluB, aluResult, result, memReadData;
	logic [4:0] shamt;
	logic aluZero, zeroReg, branchTaken;

	sequencer seq (
		.clk(clk),
		.reset(reset),
		.loadInstr(loadInstr),
		.loadOperands(loadOperands),
		.loadResult(loadResult),
		.commit(commit)
	);

	assign fetch = loadInstr;

	always_ff @(posedge clk) begin
		if (loadInstr) begin
			instrReg <= instr;
		end
		if (loadOperands) begin
			operandA <= readData1;
			operandB <= readData2;
		end
		if (loadResult) begin
			result <= aluResult;
			zeroReg <= aluZero;
		end
	end

	// Zero opcode means the funct field picks the operation
	always_comb begin
		opFunc.source = (instrReg.r.opcode == 6'd0) ? sourceFunc : sourceOp;
		opFunc.code = (instrReg.r.opcode == 6'd0) ? instrReg.r.funct : instrReg.r.opcode;
	end

	instructionCategorize categorize (
		.opFunc(opFunc),
		.category(category)
	);

	controlGenerate ctrl (
		.opFunc(opFunc),
		.category(category),
		.control(control)
	);

	assign readAddr1 = (control.reg1AddrSource == reg1Rt) ? instrReg.r.rt : instrReg.r.rs;

	registerFile regs (
		.clk(clk),
		.readAddr1(readAddr1),
		.readAddr2(instrReg.r.rt),
		.readData1(readData1),
		.readData2(readData2),
		.write(regWrite)
	);

	always_comb begin
		case (control.aluData2Source)
			aluData2ImmSigned:
				aluB = {{16{instrReg.i.immediate[15]}}, instrReg.i.immediate};
			aluData2ImmUnsigned:
				aluB = {16'd0, instrReg.i.immediate};
			default:
				aluB = operandB;
		endcase
		case (control.shamtSource)
			shamtFromShamt:
				shamt = instrReg.r.shamt;
			shamtConst16:
				shamt = 5'd16;
			default:
				shamt = 5'd0;
		endcase
	end

	alu arith (
		.op(control.aluOp),
		.a(operandA),
		.b(aluB),
		.shamt(shamt),
		.result(aluResult),
		.zero(aluZero)
	);

	dataMemory dmem (
		.clk(clk),
		.readAddr(result[`dataMemDepthLog2+1:2]),
		.readData(memReadData),
		.write(memWrite)
	);

	assign branchTaken = (control.branchCond == branchEq) ? zeroReg : !zeroReg;

	pcCounter pcReg (
		.clk(clk),
		.reset(reset),
		.commit(commit),
		.action(control.pcAction),
		.branchTaken(branchTaken),
		.offset(instrReg.i.immediate),
		.target(instrReg.j.target),
		.jumpRegister(category.rJump),
		.registerValue(operandA),
		.pc(pc)
	);

	// Both write strobes fire only in Writeback
	assign regWrite.enable = commit && control.regWriteEnable;
	assign regWrite.addr = (control.regWriteAddrSource == writeAddrRd) ?
		instrReg.r.rd : instrReg.r.rt;
	assign regWrite.data = (control.regWriteDataSource == writeDataMemory) ?
		memReadData : result;

	assign memWrite.enable = commit && control.memWriteEnable;
	assign memWrite.addr = result[`dataMemDepthLog2+1:2];
	assign memWrite.data = operandB;

endmodule

// ==== testbench/mipsCoreTb.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module mipsCoreTb;
	import mipsInstrPkg::*;
	import mipsControlPkg::*;

	localparam int instrCount = 1500;
	localparam int timeoutCycles = instrCount * 4 + 20;
	localparam int programWords = 256;

	logic clk;
	logic reset;
	instrWordU instr;
	logic [`instrAddrWidth-1:0] pc;
	logic fetch;
	regWriteT regWrite;
	memWriteT memWrite;

	instrWordU programMem [programWords];
	logic [31:0] lcgState = 32'hbcd0c9f0;
	int cycleCount = 0;

	// Reference machine state
	logic [`dataWidth-1:0] modelRegs [32];
	logic [`dataWidth-1:0] modelMem [1 << `dataMemDepthLog2];
	logic [31:0] modelPc;

	mipsCore u_dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.pc(pc),
		.fetch(fetch),
		.regWrite(regWrite),
		.memWrite(memWrite)
	);

	// Instruction port answers straight from the program, wrapping at 256 words
	assign instr = programMem[pc[9:2]];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = nextRandom();
		return int'(r[30:8]) % n;
	endfunction

	function automatic logic [15:0] randImm16();
		logic [31:0] r;
		r = nextRandom();
		return r[23:8];
	endfunction

	function automatic instrWordU makeR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
		instrWordU w;
		w.r.opcode = 6'h00;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = shamt;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic instrWordU makeI(input logic [5:0] opcode, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instrWordU w;
		w.i.opcode = opcode;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.immediate = imm;
		return w;
	endfunction

	function automatic instrWordU makeJ(input logic [25:0] target);
		instrWordU w;
		w.j.opcode = 6'h02;
		w.j.target = target;
		return w;
	endfunction

	// Offset from the slot after index to a random word of the program
	function automatic logic [15:0] branchOffset(input int index);
		return 16'(randBelow(programWords) - index - 1);
	endfunction

	task automatic buildProgram();
		int i;
		int kind;
		logic [4:0] src1;
		logic [4:0] src2;
		logic [4:0] dest;
		// Seed r1 to r6 with random values and r7 with a program address
		for (int k = 1; k < 7; k++) begin
			programMem[k - 1] = makeI(6'h09, 5'd0, 5'(k), randImm16());
		end
		programMem[6] = makeI(6'h09, 5'd0, 5'd7, 16'(randBelow(programWords) * 4));
		i = 7;
		while (i < programWords) begin
			kind = randBelow(17);
			src1 = 5'(randBelow(8));
			src2 = 5'(randBelow(8));
			// r7 is kept for jr targets
			dest = 5'(randBelow(7));
			case (kind)
				0: programMem[i] = makeR(src1, src2, dest, 5'd0, 6'h21);
				1: programMem[i] = makeR(src1, src2, dest, 5'd0, 6'h23);
				2: programMem[i] = makeR(src1, src2, dest, 5'd0, 6'h24);
				3: programMem[i] = makeR(src1, src2, dest, 5'd0, 6'h25);
				4: programMem[i] = makeR(src1, src2, dest, 5'd0, 6'h2a);
				5: programMem[i] = makeR(5'd0, src2, dest, 5'(randBelow(32)), 6'h00);
				6: programMem[i] = makeR(5'd0, src2, dest, 5'(randBelow(32)), 6'h02);
				7: begin
					if (i < programWords - 1) begin
						programMem[i] = makeI(6'h09, 5'd0, 5'd7,
							16'(randBelow(programWords) * 4));
						i++;
						programMem[i] = makeR(5'd7, 5'd0, 5'd0, 5'd0, 6'h08);
					end else begin
						programMem[i] = makeR(src1, src2, dest, 5'd0, 6'h21);
					end
				end
				8: programMem[i] = makeI(6'h09, src1, dest, randImm16());
				9: programMem[i] = makeI(6'h0c, src1, dest, randImm16());
				10: programMem[i] = makeI(6'h0d, src1, dest, randImm16());
				11: programMem[i] = makeI(6'h0f, 5'd0, dest, randImm16());
				12: programMem[i] = makeI(6'h23, 5'd0, dest, 16'(randBelow(64) * 4));
				13: programMem[i] = makeI(6'h2b, 5'd0, src2, 16'(randBelow(64) * 4));
				14: programMem[i] = makeI(6'h04, src1, src2, branchOffset(i));
				15: programMem[i] = makeI(6'h05, src1, src2, branchOffset(i));
				default: programMem[i] = makeJ(26'(randBelow(programWords)));
			endcase
			i++;
		end
	endtask

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "run aborted");
	endtask

	task automatic reportMismatch(input string signalName, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR at %0t ns: %s expected %0h, got %0h", $time, signalName, expected,
			actual);
		$display("sim failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic checkRegWrite(input regWriteT actual, input regWriteT expected);
		if (actual.enable !== expected.enable)
			reportMismatch("regWrite.enable", 32'(expected.enable), 32'(actual.enable));
		if (expected.enable) begin
			if (actual.addr !== expected.addr)
				reportMismatch("regWrite.addr", 32'(expected.addr), 32'(actual.addr));
			if (actual.data !== expected.data)
				reportMismatch("regWrite.data", expected.data, actual.data);
		end
	endtask

	task automatic checkMemWrite(input memWriteT actual, input memWriteT expected);
		if (actual.enable !== expected.enable)
			reportMismatch("memWrite.enable", 32'(expected.enable), 32'(actual.enable));
		if (expected.enable) begin
			if (actual.addr !== expected.addr)
				reportMismatch("memWrite.addr", 32'(expected.addr), 32'(actual.addr));
			if (actual.data !== expected.data)
				reportMismatch("memWrite.data", expected.data, actual.data);
		end
	endtask

	task automatic checkPc(input logic [31:0] actual, input logic [31:0] expected);
		if (actual !== expected)
			reportMismatch("pc", expected, actual);
	endtask

	task automatic checkFetch(input logic actual, input logic expected);
		if (actual !== expected)
			reportMismatch("fetch", 32'(expected), 32'(actual));
	endtask

	// One instruction of the ISA, with the writes it should report
	task automatic modelStep(input instrWordU word, output regWriteT expReg,
		output memWriteT expMem);
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] sextImm;
		logic [31:0] zextImm;
		logic [31:0] pcNext;
		logic [31:0] memAddr;
		logic [31:0] value;
		logic [4:0] dest;
		logic writes;
		rsVal = modelRegs[word.r.rs];
		rtVal = modelRegs[word.r.rt];
		sextImm = {{16{word.i.immediate[15]}}, word.i.immediate};
		zextImm = {16'd0, word.i.immediate};
		memAddr = rsVal + sextImm;
		pcNext = modelPc + 4;
		expReg = '0;
		expMem = '0;
		writes = 1'b1;
		dest = word.i.rt;
		value = '0;
		case (word.r.opcode)
			6'h00: begin
				dest = word.r.rd;
				case (word.r.funct)
					6'h21: value = rsVal + rtVal;
					6'h23: value = rsVal - rtVal;
					6'h24: value = rsVal & rtVal;
					6'h25: value = rsVal | rtVal;
					6'h2a: value = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
					6'h00: value = rtVal << word.r.shamt;
					6'h02: value = rtVal >> word.r.shamt;
					6'h08: begin
						writes = 1'b0;
						pcNext = rsVal;
					end
					default: abortRun("model met an unsupported funct code");
				endcase
			end
			6'h09: value = rsVal + sextImm;
			6'h0c: value = rsVal & zextImm;
			6'h0d: value = rsVal | zextImm;
			6'h0f: value = {word.i.immediate, 16'd0};
			6'h23: value = modelMem[memAddr[`dataMemDepthLog2+1:2]];
			6'h2b: begin
				writes = 1'b0;
				expMem.enable = 1'b1;
				expMem.addr = memAddr[`dataMemDepthLog2+1:2];
				expMem.data = rtVal;
				modelMem[memAddr[`dataMemDepthLog2+1:2]] = rtVal;
			end
			6'h04: begin
				writes = 1'b0;
				if (rsVal == rtVal)
					pcNext = pcNext + (sextImm << 2);
			end
			6'h05: begin
				writes = 1'b0;
				if (rsVal != rtVal)
					pcNext = pcNext + (sextImm << 2);
			end
			6'h02: begin
				writes = 1'b0;
				pcNext = {pcNext[31:28], word.j.target, 2'b00};
			end
			default: abortRun("model met an unsupported opcode");
		endcase
		if (writes) begin
			expReg.enable = 1'b1;
			expReg.addr = dest;
			expReg.data = value;
			// r0 writes still show on the port
			if (dest != '0)
				modelRegs[dest] = value;
		end
		modelPc = pcNext;
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > timeoutCycles)
			abortRun($sformatf("timeout: run did not finish within %0d cycles",
				timeoutCycles));
	end

	initial begin
		regWriteT expReg;
		memWriteT expMem;
		reset = 1'b1;
		for (int k = 0; k < 32; k++) begin
			modelRegs[k] = '0;
		end
		for (int k = 0; k < (1 << `dataMemDepthLog2); k++) begin
			modelMem[k] = '0;
		end
		modelPc = '0;
		buildProgram();
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;
		@(negedge clk);
		for (int n = 0; n < instrCount; n++) begin
			// Fetch
			checkFetch(fetch, 1'b1);
			checkPc(pc, modelPc);
			checkRegWrite(regWrite, '0);
			checkMemWrite(memWrite, '0);
			modelStep(programMem[modelPc[9:2]], expReg, expMem);
			// Decode and Execute
			repeat (2) begin
				@(negedge clk);
				checkFetch(fetch, 1'b0);
				checkRegWrite(regWrite, '0);
				checkMemWrite(memWrite, '0);
			end
			// Writeback
			@(negedge clk);
			checkFetch(fetch, 1'b0);
			checkRegWrite(regWrite, expReg);
			checkMemWrite(memWrite, expMem);
			@(negedge clk);
		end
		$display("sim passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+design
design/mipsInstrPkg.sv
design/mipsControlPkg.sv
design/instructionCategorize.sv
design/controlGenerate.sv
design/sequencer.sv
design/pcCounter.sv
design/registerFile.sv
design/alu.sv
design/dataMemory.sv
design/mipsCore.sv
testbench/mipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module mipsCoreTb -o mipsCoreTbSim

./obj_dir/mipsCoreTbSim
